/* src/bbox_consts.svh */
/*
 * bounding-box stage constants
 * coordinate format, triangle shape and one-hot MSAA codes
 */
`ifndef BBOX_CONSTS_SVH
`define BBOX_CONSTS_SVH

// width of every signed fixed-point coordinate word
`define BBOX_SIGFIG 24
// fraction bits at the bottom of each coordinate
`define BBOX_RADIX 10

// vertices per triangle
`define BBOX_VERTS 3
// axes per vertex, x y z
`define BBOX_AXIS 3

// one-hot sample rate codes, msb is 1x
`define BBOX_MSAA_1X 4'b1000
`define BBOX_MSAA_4X 4'b0100
// quarter-pixel grid
`define BBOX_MSAA_16X 4'b0010
// eighth-pixel grid
`define BBOX_MSAA_64X 4'b0001

`endif

/* src/bbox_pkg.sv */
/*
 * bounding-box stage types
 * coordinates, vertices, triangles, boxes and the items that
 * travel down the two-stage pipeline
 */
`include "bbox_consts.svh"

package bbox_pkg;

    // signed fixed point, integer part above the radix
    typedef logic signed [`BBOX_SIGFIG-1:0] coord_t;

    // one vertex, z rides along untouched
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    // index 0 is the first vertex
    typedef vertex_t [`BBOX_VERTS-1:0] tri_t;

    // screen-space point, also used for the screen size
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // lower-left and upper-right corners
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    // one-hot sample rate, see the BBOX_MSAA codes
    typedef logic [3:0] msaa_t;

    // pipeline input, valid low means bubble
    typedef struct packed {
        logic valid;
        tri_t triangle;
    } tri_item_t;

    // stage 1 and stage 2 output
    typedef struct packed {
        logic valid;
        tri_t triangle;
        box_t box;
    } box_item_t;

endpackage

/* src/bbox_extent.sv */
/*
 * bounding-box extent, pipeline stage 1
 * min/max search over the vertices, then floor of both corners
 * to the sample grid picked by the one-hot MSAA code
 */
`timescale 1ns/1ps
`include "bbox_consts.svh"

module bbox_extent (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                advance,
    input  bbox_pkg::tri_item_t in_item,
    input  bbox_pkg::msaa_t     msaa,
    output bbox_pkg::box_item_t ext_item
);

    // box straight from the vertex extremes
    bbox_pkg::box_t raw_box;
    // same box snapped down onto the sample grid
    bbox_pkg::box_t grid_box;

    // fraction bits that survive the floor
    logic [`BBOX_RADIX-1:0] frac_mask;
    // full-word mask, integer part always kept
    logic [`BBOX_SIGFIG-1:0] grid_mask;

    // clear every fraction bit below the grid
    // two's complement, so this floors toward minus infinity
    function automatic bbox_pkg::coord_t floor_grid(
        input bbox_pkg::coord_t        c,
        input logic [`BBOX_SIGFIG-1:0] m
    );
        return c & m;
    endfunction

    // min/max search
    // start from vertex 0, let the others pull each edge outward
    always_comb begin : extent_search
        raw_box.ll.x = in_item.triangle[0].x;
        raw_box.ll.y = in_item.triangle[0].y;
        raw_box.ur.x = in_item.triangle[0].x;
        raw_box.ur.y = in_item.triangle[0].y;
        for (int v = 1; v < `BBOX_VERTS; v++) begin
            // left edge
            if (in_item.triangle[v].x < raw_box.ll.x) begin
                raw_box.ll.x = in_item.triangle[v].x;
            end
            // bottom edge
            if (in_item.triangle[v].y < raw_box.ll.y) begin
                raw_box.ll.y = in_item.triangle[v].y;
            end
            // right edge
            if (in_item.triangle[v].x > raw_box.ur.x) begin
                raw_box.ur.x = in_item.triangle[v].x;
            end
            // top edge
            if (in_item.triangle[v].y > raw_box.ur.y) begin
                raw_box.ur.y = in_item.triangle[v].y;
            end
        end
    end

    // sample grid select
    // 1x keeps no fraction bits, 64x keeps the top three
    always_comb begin : grid_select
        frac_mask = '0;
        case (msaa)
            `BBOX_MSAA_1X: begin
                // whole pixels only
                frac_mask = '0;
            end
            `BBOX_MSAA_4X: begin
                // half pixel
                frac_mask[`BBOX_RADIX-1] = 1'b1;
            end
            `BBOX_MSAA_16X: begin
                // quarter pixel
                frac_mask[`BBOX_RADIX-1 -: 2] = 2'b11;
            end
            `BBOX_MSAA_64X: begin
                // eighth pixel
                frac_mask[`BBOX_RADIX-1 -: 3] = 3'b111;
            end
            default: begin
                // unknown code falls back to 1x
                frac_mask = '0;
            end
        endcase
    end

    assign grid_mask = {{(`BBOX_SIGFIG-`BBOX_RADIX){1'b1}}, frac_mask};

    // both corners floor, the clip stage rounds nothing
    assign grid_box.ll.x = floor_grid(raw_box.ll.x, grid_mask);
    assign grid_box.ll.y = floor_grid(raw_box.ll.y, grid_mask);
    assign grid_box.ur.x = floor_grid(raw_box.ur.x, grid_mask);
    assign grid_box.ur.y = floor_grid(raw_box.ur.y, grid_mask);

    // stage 1 register
    // loads only while advance is high, otherwise holds for downstream
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_item <= '0;
        end else if (advance) begin
            ext_item.valid    <= in_item.valid;
            // triangle travels with its box
            ext_item.triangle <= in_item.triangle;
            ext_item.box      <= grid_box;
        end
    end

endmodule

/* src/bbox_clip.sv */
/*
 * bounding-box clip, pipeline stage 2
 * clamps the floored box to the screen and drops triangles
 * whose clamped box is empty, i.e. wholly off screen
 */
`timescale 1ns/1ps

module bbox_clip (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                advance,
    input  bbox_pkg::box_item_t ext_item,
    input  bbox_pkg::point_t    screen,
    output bbox_pkg::box_item_t out_item
);

    // box after clamping to 0..screen
    bbox_pkg::box_t clip_box;

    // per-axis non-empty flags after the clamp
    logic x_ok;
    logic y_ok;
    // valid bit headed into stage 2
    logic clip_valid;

    // lower bound of the screen is the origin
    function automatic bbox_pkg::coord_t clamp_lo(input bbox_pkg::coord_t c);
        if (c < 0) begin
            return '0;
        end
        return c;
    endfunction

    // upper bound is the screen size on that axis
    function automatic bbox_pkg::coord_t clamp_hi(
        input bbox_pkg::coord_t c,
        input bbox_pkg::coord_t limit
    );
        if (c > limit) begin
            return limit;
        end
        return c;
    endfunction

    // screen clamp
    // x and y handled independently, both corners every cycle
    always_comb begin : screen_clamp
        clip_box.ll.x = clamp_lo(ext_item.box.ll.x);
        clip_box.ll.y = clamp_lo(ext_item.box.ll.y);
        clip_box.ur.x = clamp_hi(ext_item.box.ur.x, screen.x);
        clip_box.ur.y = clamp_hi(ext_item.box.ur.y, screen.y);
    end

    // empty-box rejection
    // a box left of the screen ends with ur below the clamped ll of 0,
    // a box right of it keeps ll above the clamped ur of screen
    assign x_ok = (clip_box.ll.x <= clip_box.ur.x);
    assign y_ok = (clip_box.ll.y <= clip_box.ur.y);

    // bubbles stay bubbles, off-screen triangles become bubbles
    assign clip_valid = ext_item.valid && x_ok && y_ok;

    // stage 2 register
    // same load/hold rule as stage 1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_item <= '0;
        end else if (advance) begin
            out_item.valid    <= clip_valid;
            out_item.triangle <= ext_item.triangle;
            // rejected items still carry their clamped box
            out_item.box      <= clip_box;
        end
    end

endmodule

/* src/bbox_top.sv */
/*
 * bounding-box stage top level
 * triangle in, clamped sample-grid box out, two advancing cycles later
 */
`timescale 1ns/1ps

module bbox_top (
    input  logic                clk,
    input  logic                arst_n,
    // global enable, low holds every stage
    input  logic                advance,
    input  bbox_pkg::tri_item_t in_item,
    // configuration, steady while items are in flight
    input  bbox_pkg::msaa_t     msaa,
    input  bbox_pkg::point_t    screen,
    output bbox_pkg::box_item_t out_item
);

    // stage 1 result, floored but not yet clamped
    bbox_pkg::box_item_t ext_item;

    // stage 1
    // extent search and grid floor
    bbox_extent extent0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .advance  (advance),
        .in_item  (in_item),
        .msaa     (msaa),
        .ext_item (ext_item)
    );

    // stage 2
    // screen clamp and off-screen rejection
    bbox_clip clip0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .advance  (advance),
        .ext_item (ext_item),
        .screen   (screen),
        .out_item (out_item)
    );

endmodule

/* dv/bbox_asserts.sv */
/*
 * bounding-box stage checker
 * bound to the top level, sees only its ports, keeps a two-deep
 * shadow of advancing inputs and checks every output against it
 */
`timescale 1ns/1ps
`include "bbox_consts.svh"

module bbox_asserts (
    input logic                clk,
    input logic                arst_n,
    input logic                advance,
    input bbox_pkg::tri_item_t in_item,
    input bbox_pkg::msaa_t     msaa,
    input bbox_pkg::point_t    screen,
    input bbox_pkg::box_item_t out_item
);

    localparam bbox_pkg::coord_t coord_zero = '0;

    // failures that print an ERR line with both values
    int value_errs = 0;
    // failures described in plain words
    int other_errs = 0;

    // inputs seen on the last two advancing edges
    bbox_pkg::tri_item_t hist1;
    bbox_pkg::tri_item_t hist2;

    // box implied by the input two advancing edges back
    bbox_pkg::box_t hist_box;
    logic want_valid;

    // bits below the grid for each sample rate
    // 1x drops every fraction bit
    function automatic int grid_shift(input bbox_pkg::msaa_t m);
        case (m)
            `BBOX_MSAA_4X:  return `BBOX_RADIX - 1;
            `BBOX_MSAA_16X: return `BBOX_RADIX - 2;
            `BBOX_MSAA_64X: return `BBOX_RADIX - 3;
            default:        return `BBOX_RADIX;
        endcase
    endfunction

    // arithmetic shift down and back up floors toward minus infinity
    function automatic bbox_pkg::coord_t snap(input bbox_pkg::coord_t c, input int sh);
        return (c >>> sh) <<< sh;
    endfunction

    function automatic bbox_pkg::box_t expect_box(
        input bbox_pkg::tri_t   t,
        input bbox_pkg::msaa_t  m,
        input bbox_pkg::point_t s
    );
        bbox_pkg::coord_t lo_x;
        bbox_pkg::coord_t hi_x;
        bbox_pkg::coord_t lo_y;
        bbox_pkg::coord_t hi_y;
        bbox_pkg::box_t   b;
        int               sh;
        sh   = grid_shift(m);
        lo_x = t[0].x;
        hi_x = t[0].x;
        lo_y = t[0].y;
        hi_y = t[0].y;
        for (int v = 1; v < `BBOX_VERTS; v++) begin
            lo_x = (t[v].x < lo_x) ? t[v].x : lo_x;
            hi_x = (t[v].x > hi_x) ? t[v].x : hi_x;
            lo_y = (t[v].y < lo_y) ? t[v].y : lo_y;
            hi_y = (t[v].y > hi_y) ? t[v].y : hi_y;
        end
        // floor first, then clamp to 0..screen
        b.ll.x = snap(lo_x, sh);
        b.ll.y = snap(lo_y, sh);
        b.ur.x = snap(hi_x, sh);
        b.ur.y = snap(hi_y, sh);
        b.ll.x = (b.ll.x < coord_zero) ? coord_zero : b.ll.x;
        b.ll.y = (b.ll.y < coord_zero) ? coord_zero : b.ll.y;
        b.ur.x = (b.ur.x > s.x) ? s.x : b.ur.x;
        b.ur.y = (b.ur.y > s.y) ? s.y : b.ur.y;
        return b;
    endfunction

    // shadow pipeline loads on the same edges as the DUT
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hist1 <= '0;
            hist2 <= '0;
        end else if (advance) begin
            hist1 <= in_item;
            hist2 <= hist1;
        end
    end

    always_comb begin
        hist_box = expect_box(hist2.triangle, msaa, screen);
        // empty or inverted after the clamp means off screen
        want_valid = hist2.valid && (hist_box.ll.x <= hist_box.ur.x) &&
                     (hist_box.ll.y <= hist_box.ur.y);
    end

    // valid stays low in reset and on the first edge after it
    reset_chk: assert property (@(posedge clk)
        (!arst_n || $rose(arst_n)) |-> !out_item.valid)
    else begin
        other_errs++;
        $error("output valid was high during or right after reset");
    end

    // corners match the floored and clamped extent of the shadowed input
    ll_x_chk: assert property (@(posedge clk) disable iff (!arst_n)
        out_item.valid |-> out_item.box.ll.x == hist_box.ll.x)
    else begin
        value_errs++;
        $error("ERR t=%0t out_item.box.ll.x expected %0d actual %0d",
               $time, $sampled(hist_box.ll.x), $sampled(out_item.box.ll.x));
    end

    ll_y_chk: assert property (@(posedge clk) disable iff (!arst_n)
        out_item.valid |-> out_item.box.ll.y == hist_box.ll.y)
    else begin
        value_errs++;
        $error("ERR t=%0t out_item.box.ll.y expected %0d actual %0d",
               $time, $sampled(hist_box.ll.y), $sampled(out_item.box.ll.y));
    end

    ur_x_chk: assert property (@(posedge clk) disable iff (!arst_n)
        out_item.valid |-> out_item.box.ur.x == hist_box.ur.x)
    else begin
        value_errs++;
        $error("ERR t=%0t out_item.box.ur.x expected %0d actual %0d",
               $time, $sampled(hist_box.ur.x), $sampled(out_item.box.ur.x));
    end

    ur_y_chk: assert property (@(posedge clk) disable iff (!arst_n)
        out_item.valid |-> out_item.box.ur.y == hist_box.ur.y)
    else begin
        value_errs++;
        $error("ERR t=%0t out_item.box.ur.y expected %0d actual %0d",
               $time, $sampled(hist_box.ur.y), $sampled(out_item.box.ur.y));
    end

    // bubbles and off-screen triangles come out invalid and the rest valid
    valid_chk: assert property (@(posedge clk) disable iff (!arst_n)
        out_item.valid == want_valid)
    else begin
        value_errs++;
        $error("ERR t=%0t out_item.valid expected %0b actual %0b",
               $time, $sampled(want_valid), $sampled(out_item.valid));
    end

    // triangle arrives unchanged two advancing edges later
    tri_chk: assert property (@(posedge clk) disable iff (!arst_n)
        want_valid |-> out_item.triangle == hist2.triangle)
    else begin
        value_errs++;
        $error("ERR t=%0t out_item.triangle expected %h actual %h",
               $time, $sampled(hist2.triangle), $sampled(out_item.triangle));
    end

    range_chk: assert property (@(posedge clk) disable iff (!arst_n)
        out_item.valid |-> (out_item.box.ll.x >= coord_zero) &&
                           (out_item.box.ll.y >= coord_zero) &&
                           (out_item.box.ll.x <= out_item.box.ur.x) &&
                           (out_item.box.ll.y <= out_item.box.ur.y) &&
                           (out_item.box.ur.x <= screen.x) &&
                           (out_item.box.ur.y <= screen.y))
    else begin
        other_errs++;
        $error("a valid output box was empty or reached outside the screen");
    end

    // a stalled edge leaves the output untouched
    hold_chk: assert property (@(posedge clk) disable iff (!arst_n)
        !advance |=> out_item == $past(out_item))
    else begin
        other_errs++;
        $error("the output changed across an edge with advance low");
    end

endmodule

bind bbox_top bbox_asserts chk0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .advance  (advance),
    .in_item  (in_item),
    .msaa     (msaa),
    .screen   (screen),
    .out_item (out_item)
);

/* dv/bbox_tb.sv */
/*
 * bounding-box stage testbench
 * random and directed triangles at all four sample rates with
 * bubbles and stalls, the bound assertions do the checking
 */
`timescale 1ns/1ps
`include "bbox_consts.svh"

module bbox_tb;

    // run limit, about four times the stimulus length
    localparam int cycle_limit = 2000;
    // random triangles per sample rate
    localparam int rand_tris = 48;

    logic                clk = 1'b0;
    logic                arst_n;
    logic                advance;
    bbox_pkg::tri_item_t in_item;
    bbox_pkg::msaa_t     msaa;
    bbox_pkg::point_t    screen;
    bbox_pkg::box_item_t out_item;

    int cycle_count = 0;
    int total_errs;

    bbox_top dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .advance  (advance),
        .in_item  (in_item),
        .msaa     (msaa),
        .screen   (screen),
        .out_item (out_item)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // whole pixels to fixed point
    function automatic bbox_pkg::coord_t to_fixed(input int whole);
        int fixed;
        fixed = whole * (1 << `BBOX_RADIX);
        return fixed[`BBOX_SIGFIG-1:0];
    endfunction

    // random whole part in lo..hi plus a random fraction
    function automatic bbox_pkg::coord_t rand_coord(input int lo, input int hi);
        int whole;
        int frac;
        int fixed;
        whole = lo + int'($urandom % (hi - lo + 1));
        frac  = int'($urandom % (1 << `BBOX_RADIX));
        fixed = whole * (1 << `BBOX_RADIX) + frac;
        return fixed[`BBOX_SIGFIG-1:0];
    endfunction

    // every fraction bit set, just below the next whole pixel
    function automatic bbox_pkg::coord_t ones_coord(input int whole);
        int fixed;
        fixed = whole * (1 << `BBOX_RADIX) + (1 << `BBOX_RADIX) - 1;
        return fixed[`BBOX_SIGFIG-1:0];
    endfunction

    // mostly spread around the screen, sometimes wholly off it
    function automatic bbox_pkg::tri_item_t random_tri(input int w, input int h);
        bbox_pkg::tri_item_t item;
        int mode;
        int x_lo;
        int x_hi;
        int y_lo;
        int y_hi;
        mode = int'($urandom % 6);
        x_lo = -w / 2;
        x_hi = w + w / 2;
        y_lo = -h / 2;
        y_hi = h + h / 2;
        case (mode)
            // left of the screen
            0: begin
                x_lo = -w;
                x_hi = -1;
            end
            // right of the screen
            1: begin
                x_lo = w + 1;
                x_hi = 2 * w;
            end
            // below the screen
            2: begin
                y_lo = -h;
                y_hi = -1;
            end
            default: begin
            end
        endcase
        item.valid = 1'b1;
        for (int v = 0; v < `BBOX_VERTS; v++) begin
            item.triangle[v].x = rand_coord(x_lo, x_hi);
            item.triangle[v].y = rand_coord(y_lo, y_hi);
            item.triangle[v].z = rand_coord(-64, 64);
        end
        return item;
    endfunction

    // small triangle anchored at x0,y0, all fraction bits ones
    function automatic bbox_pkg::tri_item_t ones_tri(input int x0, input int y0);
        bbox_pkg::tri_item_t item;
        item.valid = 1'b1;
        item.triangle[0].x = ones_coord(x0);
        item.triangle[0].y = ones_coord(y0);
        item.triangle[0].z = ones_coord(0);
        item.triangle[1].x = ones_coord(x0 + 3);
        item.triangle[1].y = ones_coord(y0 + 1);
        item.triangle[1].z = ones_coord(1);
        item.triangle[2].x = ones_coord(x0 + 1);
        item.triangle[2].y = ones_coord(y0 + 4);
        item.triangle[2].z = ones_coord(-2);
        return item;
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    // hold the pipeline 1 to 5 cycles while the input wanders
    task automatic stall();
        bbox_pkg::tri_item_t junk;
        int len;
        len = 1 + int'($urandom % 5);
        advance = 1'b0;
        repeat (len) begin
            junk = random_tri(64, 48);
            junk.valid = 1'($urandom % 2);
            in_item = junk;
            next_edge();
        end
    endtask

    task automatic push(input bbox_pkg::tri_item_t item);
        bbox_pkg::tri_item_t gap;
        if ($urandom % 5 == 0) begin
            stall();
        end
        advance = 1'b1;
        in_item = item;
        next_edge();
        // occasional bubble, triangle bits are noise
        if ($urandom % 4 == 0) begin
            gap = random_tri(64, 48);
            gap.valid = 1'b0;
            in_item = gap;
            next_edge();
        end
    endtask

    // flush with bubbles so config may change
    task automatic drain();
        advance = 1'b1;
        in_item = '0;
        repeat (3) begin
            next_edge();
        end
    endtask

    task automatic run_phase(input bbox_pkg::msaa_t code, input int w, input int h);
        msaa     = code;
        screen.x = to_fixed(w);
        screen.y = to_fixed(h);
        for (int n = 0; n < rand_tris; n++) begin
            push(random_tri(w, h));
        end
        // directed cases around the origin and the far corner
        push(ones_tri(-1, -1));
        push(ones_tri(0, 0));
        push(ones_tri(5, 7));
        push(ones_tri(w - 2, h - 3));
        push(ones_tri(w, h));
        push(ones_tri(-5, h - 1));
        push(ones_tri(w - 1, -4));
        push(ones_tri(12, -9));
        drain();
    endtask

    task automatic report_counts();
        $display("error counts: %0d value mismatches, %0d other check failures",
                 dut0.chk0.value_errs, dut0.chk0.other_errs);
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            report_counts();
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        void'($urandom(19));
        arst_n  = 1'b0;
        advance = 1'b0;
        in_item = '0;
        msaa    = `BBOX_MSAA_1X;
        screen  = '0;
        repeat (10) begin
            @(posedge clk);
        end
        #2;
        arst_n = 1'b1;
        run_phase(`BBOX_MSAA_1X, 640, 480);
        run_phase(`BBOX_MSAA_4X, 320, 240);
        run_phase(`BBOX_MSAA_16X, 1920, 1080);
        run_phase(`BBOX_MSAA_64X, 100, 80);
        // let the last assertion attempts complete
        repeat (2) begin
            next_edge();
        end
        total_errs = dut0.chk0.value_errs + dut0.chk0.other_errs;
        report_counts();
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/bbox_pkg.sv
src/bbox_extent.sv
src/bbox_clip.sv
src/bbox_top.sv
dv/bbox_asserts.sv
dv/bbox_tb.sv

/* run.sh */
#!/bin/sh
# build the bounding-box testbench with Verilator, run it, then judge the log
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module bbox_tb -o bbox_sim \
    && ./obj_dir/bbox_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "FAIL: build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }
